// File: verif/eeprom_testdata.txt
// Columns in hex: op addr data ackErr rdData group
// op 0 is a write, 1 a read; rdData is 00 for writes
// Write then read back
0 10 3C 0 00 1
1 10 00 0 3C 1
// Unwritten address reads address XOR A5
1 22 00 0 87 2
// Five mixed commands, four wait in the queue behind the first
0 40 5A 0 00 3
1 41 00 0 E4 3
0 42 C3 0 00 3
1 40 00 0 5A 3
1 42 00 0 C3 3
// Word address F0 and up is NACKed, a normal read still works after it
0 F2 11 1 00 4
1 F5 00 1 00 4
1 10 00 0 3C 4
// Last good address and address zero
0 EF FF 0 00 5
1 EF 00 0 FF 5
1 00 00 0 A5 5

// File: compile.f
+incdir+logic
logic/eepromPkg.sv
logic/cmdQueue.sv
logic/eepromSequencer.sv
logic/i2cMaster.sv
logic/eepromTop.sv
verif/clockGen.sv
verif/eepromModel.sv
verif/eepromTb.sv

// File: Bender.yml
package:
  name: eeprom_access

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/eepromPkg.sv
      - logic/cmdQueue.sv
      - logic/eepromSequencer.sv
      - logic/i2cMaster.sv
      - logic/eepromTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/clockGen.sv
      - verif/eepromModel.sv
      - verif/eepromTb.sv

// File: verif/eepromTb.sv
`timescale 1ns/1ps
`include "eeprom_defines.svh"

module eepromTb
    import eepromPkg::*;
();

    localparam int clkPeriodNs  = 40;
    localparam int maxCmds      = 64;
    localparam int fieldsPerCmd = 6;           // op addr data ackErr rdData group

    logic       CLK;
    logic       RSTn;
    logic       cmdValid;
    cmdOpT      cmdOp;
    logic [7:0] cmdAddr;
    logic [7:0] cmdData;
    logic       cmdFull;
    logic       rspValid;
    cmdOpT      rspOp;
    logic [7:0] rspAddr;
    logic [7:0] rspData;
    logic       rspAckErr;
    logic       SCL;
    wire        SDA;
    int         protoErrors;

    logic [7:0] testData [fieldsPerCmd * maxCmds];
    int         numCmds;
    int         pending [$];                  // Indices awaiting a response
    int         cycleCount = 0;
    int         cycleLimit = 2000000;
    int         errorCount = 0;
    int         testsRun = 0;
    int         testsFailed = 0;
    logic       sawFull = 1'b0;

    clockGen #(.periodNs(clkPeriodNs), .resetCycles(16)) clk0 (
        .CLK  (CLK),
        .RSTn (RSTn)
    );

    eepromTop dut0 (
        .CLK       (CLK),
        .RSTn      (RSTn),
        .cmdValid  (cmdValid),
        .cmdOp     (cmdOp),
        .cmdAddr   (cmdAddr),
        .cmdData   (cmdData),
        .cmdFull   (cmdFull),
        .rspValid  (rspValid),
        .rspOp     (rspOp),
        .rspAddr   (rspAddr),
        .rspData   (rspData),
        .rspAckErr (rspAckErr),
        .SCL       (SCL),
        .SDA       (SDA)
    );

    pullup (SDA);

    eepromModel #(.bitNs(`I2C_BIT_CYCLES * clkPeriodNs)) model0 (
        .SCL         (SCL),
        .SDA         (SDA),
        .protoErrors (protoErrors)
    );

    function automatic logic [7:0] fieldOf(input int idx, input int col);
        return testData[idx * fieldsPerCmd + col];
    endfunction

    task automatic compareValues(input string name, input logic [7:0] got,
                                 input logic [7:0] want);
        if (got !== want)
        begin
            errorCount++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic finishTest(input string what, input int errsBefore);
        testsRun++;
        if (errorCount != errsBefore)
        begin
            testsFailed++;
            $display("Test %0d %s failed", testsRun, what);
        end
        else
            $display("Test %0d %s passed", testsRun, what);
    endtask

    // Called on a falling edge, returns on the next one
    task automatic pushCommand(input int idx);
        logic [7:0] opField;
        opField = fieldOf(idx, 0);
        while (cmdFull)
            @(negedge CLK);                     // Host stalls on a full queue
        cmdValid = 1'b1;
        cmdOp    = opField[0] ? opRead : opWrite;
        cmdAddr  = fieldOf(idx, 1);
        cmdData  = fieldOf(idx, 2);
        pending.push_back(idx);
        @(negedge CLK);
        cmdValid = 1'b0;
    endtask

    always @(posedge CLK)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("Timeout, the run did not finish within %0d clock cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    always @(negedge CLK)
    begin
        if (cmdFull)
            sawFull = 1'b1;
    end

    // Responses must come back in push order
    always @(negedge CLK)
    begin
        int idx;
        int errsBefore;
        if (RSTn && rspValid)
        begin
            if (pending.size() == 0)
            begin
                errorCount++;
                $display("Response for address %h arrived with no command pending", rspAddr);
            end
            else
            begin
                idx = pending.pop_front();
                errsBefore = errorCount;
                compareValues("rspOp", 8'(rspOp), fieldOf(idx, 0));
                compareValues("rspAddr", rspAddr, fieldOf(idx, 1));
                compareValues("rspAckErr", 8'(rspAckErr), fieldOf(idx, 3));
                if (fieldOf(idx, 0) == 8'h00 || fieldOf(idx, 3) == 8'h00)
                    compareValues("rspData", rspData, fieldOf(idx, 4));
                finishTest($sformatf("%s addr %h", (fieldOf(idx, 0) == 8'h01) ? "read" : "write",
                    fieldOf(idx, 1)), errsBefore);
            end
        end
    end

    initial
    begin
        int errsBefore;
        int grp;
        int first;
        int last;
        cmdValid = 1'b0;
        cmdOp    = opWrite;
        cmdAddr  = 8'h00;
        cmdData  = 8'h00;
        for (int i = 0; i < fieldsPerCmd * maxCmds; i++)
            testData[i] = 8'hFF;                // End marker in the op column
        $readmemh("verif/eeprom_testdata.txt", testData);
        numCmds = 0;
        while (numCmds < maxCmds && fieldOf(numCmds, 0) != 8'hFF)
            numCmds++;
        cycleLimit = numCmds * 45 * `I2C_BIT_CYCLES + 5000;

        wait (RSTn === 1'b1);
        @(negedge CLK);
        errsBefore = errorCount;
        compareValues("SCL", 8'(SCL), 8'h01);
        compareValues("SDA", 8'(SDA), 8'h01);
        compareValues("rspValid", 8'(rspValid), 8'h00);
        compareValues("cmdFull", 8'(cmdFull), 8'h00);
        if (numCmds == 0)
        begin
            errorCount++;
            $display("No commands were found in the test data file");
        end
        finishTest("reset state", errsBefore);

        first = 0;
        while (first < numCmds)
        begin
            grp  = fieldOf(first, 5);
            last = first;
            while (last + 1 < numCmds && fieldOf(last + 1, 5) == grp)
                last++;
            sawFull = 1'b0;
            for (int i = first; i <= last; i++)
                pushCommand(i);
            while (pending.size() > 0)
                @(negedge CLK);
            if (last - first + 1 > `CMD_QUEUE_DEPTH)
            begin
                errsBefore = errorCount;
                if (!sawFull)
                begin
                    errorCount++;
                    $display("cmdFull never rose while group %0d filled the queue", grp);
                end
                finishTest($sformatf("group %0d queue full", grp), errsBefore);
            end
            first = last + 1;
        end

        errsBefore = errorCount;
        if (protoErrors != 0)
        begin
            errorCount++;
            $display("The EEPROM model saw %0d bus protocol violations", protoErrors);
        end
        finishTest("bus protocol", errsBefore);

        $display("Tests run %0d, passed %0d, failed %0d, checks with errors %0d",
            testsRun, testsRun - testsFailed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verif/eepromModel.sv
`timescale 1ns/1ps
`include "eeprom_defines.svh"

module eepromModel #(
    parameter int bitNs = 20000
) (
    input  wire SCL,
    inout  wire SDA,
    output int  protoErrors
);

    typedef enum int {
        phIdle,
        phDev,
        phWord,
        phData,
        phRead,
        phWait
    } busPhase;

    logic [7:0] mem [256];
    busPhase    phase     = phIdle;
    int         bitCnt    = 0;
    logic [7:0] rxByte    = 8'h00;
    logic [7:0] txByte    = 8'h00;
    logic [7:0] wordAddr  = 8'h00;
    logic [7:0] dataByte  = 8'h00;
    logic       wrPending = 1'b0;
    logic       ackNext   = 1'b0;
    logic       toRead    = 1'b0;
    logic       sdaLow    = 1'b0;

    assign SDA = sdaLow ? 1'b0 : 1'bz;          // Open drain

    initial
    begin
        protoErrors = 0;
        for (int a = 0; a < 256; a++)
            mem[a] = 8'(a) ^ 8'hA5;             // Unwritten cells
    end

    // Decide the answer once eight bits have passed
    task byteDone;
        case (phase)
            phDev:
            begin
                ackNext = (rxByte[7:1] == `EEPROM_DEV_ADDR);
                if (!ackNext)
                    phase = phWait;
                else if (rxByte[0])
                begin
                    toRead = 1'b1;              // Read starts after the ACK slot
                    phase  = phWait;
                end
                else
                    phase = phWord;
            end
            phWord:
            begin
                ackNext = (rxByte < 8'hF0);     // Upper word addresses are NACKed
                wordAddr = rxByte;
                phase = ackNext ? phData : phWait;
            end
            phData:
            begin
                dataByte  = rxByte;
                wrPending = 1'b1;               // Committed on STOP
                ackNext   = 1'b1;
                phase     = phWait;
            end
            default:
                ackNext = 1'b0;
        endcase
    endtask

    // START and STOP are the only SDA moves allowed with SCL high
    always @(SDA)
    begin
        if (SCL === 1'b1)
        begin
            if (bitCnt > 1 || sdaLow)
            begin
                protoErrors++;
                $display("EEPROM model saw SDA change while SCL was high inside a byte at %0t",
                    $time);
            end
            if (SDA === 1'b0)
            begin
                phase     = phDev;
                bitCnt    = 0;
                toRead    = 1'b0;
                wrPending = 1'b0;
            end
            else if (SDA === 1'b1)
            begin
                if (wrPending)
                    mem[wordAddr] = dataByte;
                wrPending = 1'b0;
                phase     = phIdle;
                bitCnt    = 0;
            end
        end
    end

    always @(posedge SCL)
    begin
        if (phase != phIdle)
        begin
            if (SDA !== 1'b0 && SDA !== 1'b1)
            begin
                protoErrors++;
                $display("EEPROM model found SDA undefined at a rising SCL at %0t", $time);
            end
            else if (bitCnt < 8)
            begin
                rxByte = {rxByte[6:0], SDA};
                bitCnt++;
                if (bitCnt == 8)
                    byteDone();
            end
            else
            begin
                bitCnt = 0;                     // ACK slot
                if (toRead)
                begin
                    toRead = 1'b0;
                    txByte = mem[wordAddr];
                    phase  = phRead;
                end
                else if (phase == phRead)
                    phase = phWait;             // Single byte reads only
            end
        end
    end

    // Let go at once, then drive the next bit well inside SCL low
    always @(negedge SCL)
    begin
        logic wantLow;
        sdaLow  = 1'b0;
        wantLow = 1'b0;
        if (phase != phIdle)
        begin
            if (bitCnt == 8)
                wantLow = ackNext;
            else if (phase == phRead)
                wantLow = !txByte[7 - bitCnt];
        end
        if (wantLow)
        begin
            #(bitNs / 2);
            if (SCL === 1'b0)
                sdaLow = 1'b1;
        end
    end

endmodule

// File: verif/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int periodNs    = 40,
    parameter int resetCycles = 16
) (
    output logic CLK,
    output logic RSTn
);

    initial
    begin
        CLK = 1'b0;
        forever
            #(periodNs / 2.0) CLK = ~CLK;
    end

    initial
    begin
        RSTn = 1'b0;
        repeat (resetCycles)
            @(posedge CLK);
        @(negedge CLK);
        RSTn = 1'b1;                            // Release away from the active edge
    end

endmodule

// File: logic/eepromTop.sv
`timescale 1ns/1ps

module eepromTop
    import eepromPkg::*;
(
    input  logic       CLK,
    input  logic       RSTn,
    input  logic       cmdValid,
    input  cmdOpT      cmdOp,
    input  logic [7:0] cmdAddr,
    input  logic [7:0] cmdData,
    output logic       cmdFull,
    output logic       rspValid,
    output cmdOpT      rspOp,
    output logic [7:0] rspAddr,
    output logic [7:0] rspData,
    output logic       rspAckErr,
    output logic       SCL,
    inout  wire        SDA
);

    // Queue head
    logic       qEmpty;
    logic       qPop;
    cmdOpT      qOp;
    logic [7:0] qAddr;
    logic [7:0] qData;

    // Sequencer and master
    logic [1:0] startSig;
    logic [7:0] mAddr;
    logic [7:0] mWrData;
    logic [7:0] mRdData;
    logic       mDone;
    logic       mAckErr;

    cmdQueue queue0 (
        .CLK      (CLK),
        .RSTn     (RSTn),
        .push     (cmdValid),
        .pushOp   (cmdOp),
        .pushAddr (cmdAddr),
        .pushData (cmdData),
        .pop      (qPop),
        .empty    (qEmpty),
        .full     (cmdFull),
        .headOp   (qOp),
        .headAddr (qAddr),
        .headData (qData)
    );

    eepromSequencer seq0 (
        .CLK       (CLK),
        .RSTn      (RSTn),
        .qEmpty    (qEmpty),
        .qOp       (qOp),
        .qAddr     (qAddr),
        .qData     (qData),
        .qPop      (qPop),
        .startSig  (startSig),
        .addr      (mAddr),
        .wrData    (mWrData),
        .done      (mDone),
        .rdData    (mRdData),
        .ackErr    (mAckErr),
        .rspValid  (rspValid),
        .rspOp     (rspOp),
        .rspAddr   (rspAddr),
        .rspData   (rspData),
        .rspAckErr (rspAckErr)
    );

    i2cMaster master0 (
        .CLK      (CLK),
        .RSTn     (RSTn),
        .startSig (startSig),
        .addr     (mAddr),
        .wrData   (mWrData),
        .rdData   (mRdData),
        .done     (mDone),
        .ackErr   (mAckErr),
        .SCL      (SCL),
        .SDA      (SDA)
    );

endmodule

// File: logic/i2cMaster.sv
`timescale 1ns/1ps
`include "eeprom_defines.svh"

module i2cMaster
    import eepromPkg::*;
(
    input  logic       CLK,
    input  logic       RSTn,
    input  logic [1:0] startSig,
    input  logic [7:0] addr,
    input  logic [7:0] wrData,
    output logic [7:0] rdData,
    output logic       done,
    output logic       ackErr,
    output logic       SCL,
    inout  wire        SDA
);

    localparam int bitCycles = `I2C_BIT_CYCLES;
    localparam int cntW = $clog2(bitCycles);
    localparam logic [cntW-1:0] lastPhase = cntW'(bitCycles - 1);
    localparam logic [cntW-1:0] fifth1 = cntW'(bitCycles / 5);
    localparam logic [cntW-1:0] fifth2 = cntW'(2 * bitCycles / 5);
    localparam logic [cntW-1:0] fifth3 = cntW'(3 * bitCycles / 5);
    localparam logic [cntW-1:0] fifth4 = cntW'(4 * bitCycles / 5);

    // Which byte the current ACK slot closes
    localparam logic [1:0] stageDevW = 2'd0;
    localparam logic [1:0] stageWord = 2'd1;
    localparam logic [1:0] stageData = 2'd2;
    localparam logic [1:0] stageDevR = 2'd3;

    masterState      state;
    logic [cntW-1:0] phaseCnt;
    logic [2:0]      bitIdx;
    logic [1:0]      stage;
    logic [7:0]      shiftReg;
    logic            rdMode;
    logic            ackBit;
    logic            sclReg;
    logic            sdaOut;
    logic            sdaEn;
    logic            bitEnd;
    logic            dataSlot;
    logic            sdaLine;

    assign bitEnd   = (phaseCnt == lastPhase);
    assign dataSlot = state inside {sendByte, ackWait, readByte, masterNack};
    assign SCL      = sclReg;
    assign SDA      = sdaEn ? sdaOut : 1'bz;          // Open drain with an external pull-up
    assign sdaLine  = sdaEn ? sdaOut : 1'b1;          // Level the master intends
    assign rdData   = shiftReg;

    // Phase within the current bit
    always_ff @(posedge CLK or negedge RSTn)
    begin
        if (!RSTn)
            phaseCnt <= '0;
        else if (state inside {idle, finish, waitRelease} || bitEnd)
            phaseCnt <= '0;
        else
            phaseCnt <= phaseCnt + 1'b1;
    end

    always_ff @(posedge CLK or negedge RSTn)
    begin
        if (!RSTn)
        begin
            state    <= idle;
            bitIdx   <= 3'd7;
            stage    <= stageDevW;
            shiftReg <= 8'h00;
            rdMode   <= 1'b0;
            ackBit   <= 1'b1;
            ackErr   <= 1'b0;
            done     <= 1'b0;
            sclReg   <= 1'b1;
            sdaOut   <= 1'b1;
            sdaEn    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;

            // Clock pulse shared by every data and ACK bit
            if (dataSlot)
            begin
                if (phaseCnt == fifth1)
                    sclReg <= 1'b1;
                else if (phaseCnt == fifth3)
                    sclReg <= 1'b0;
            end

            case (state)
                idle:
                begin
                    sclReg <= 1'b1;
                    sdaOut <= 1'b1;
                    sdaEn  <= 1'b0;
                    if (startSig != 2'b00)
                    begin
                        rdMode <= startSig[1];
                        ackErr <= 1'b0;
                        state  <= start;
                    end
                end
                start:
                begin
                    sdaEn <= 1'b1;
                    if (phaseCnt == fifth2)
                        sdaOut <= 1'b0;              // SDA falls while SCL high
                    if (phaseCnt == fifth4)
                        sclReg <= 1'b0;
                    if (bitEnd)
                    begin
                        shiftReg <= {`EEPROM_DEV_ADDR, 1'b0};
                        stage    <= stageDevW;
                        bitIdx   <= 3'd7;
                        state    <= sendByte;
                    end
                end
                sendByte:
                begin
                    if (phaseCnt == '0)
                    begin
                        sdaEn  <= 1'b1;
                        sdaOut <= shiftReg[bitIdx];  // Data set up while SCL low
                    end
                    if (bitEnd)
                    begin
                        bitIdx <= bitIdx - 3'd1;     // Wraps back to 7
                        if (bitIdx == 3'd0)
                            state <= ackWait;
                    end
                end
                ackWait:
                begin
                    if (phaseCnt == '0)
                        sdaEn <= 1'b0;
                    if (phaseCnt == fifth2)
                        ackBit <= SDA;               // Middle of SCL high
                    if (bitEnd)
                    begin
                        if (ackBit)
                        begin
                            ackErr <= 1'b1;          // NACK releases the bus and reports
                            state  <= stop;
                        end
                        else
                        begin
                            case (stage)
                                stageDevW:
                                begin
                                    shiftReg <= addr;
                                    stage    <= stageWord;
                                    state    <= sendByte;
                                end
                                stageWord:
                                begin
                                    if (rdMode)
                                        state <= restart;
                                    else
                                    begin
                                        shiftReg <= wrData;
                                        stage    <= stageData;
                                        state    <= sendByte;
                                    end
                                end
                                stageData:
                                    state <= stop;
                                default:
                                    state <= readByte;
                            endcase
                        end
                    end
                end
                restart:
                begin
                    if (phaseCnt == '0)
                    begin
                        sdaEn  <= 1'b1;
                        sdaOut <= 1'b1;
                    end
                    if (phaseCnt == fifth1)
                        sclReg <= 1'b1;
                    if (phaseCnt == fifth3)
                        sdaOut <= 1'b0;              // Repeated START
                    if (phaseCnt == fifth4)
                        sclReg <= 1'b0;
                    if (bitEnd)
                    begin
                        shiftReg <= {`EEPROM_DEV_ADDR, 1'b1};
                        stage    <= stageDevR;
                        state    <= sendByte;
                    end
                end
                readByte:
                begin
                    if (phaseCnt == '0)
                        sdaEn <= 1'b0;
                    if (phaseCnt == fifth2)
                        shiftReg[bitIdx] <= SDA;
                    if (bitEnd)
                    begin
                        bitIdx <= bitIdx - 3'd1;
                        if (bitIdx == 3'd0)
                            state <= masterNack;
                    end
                end
                masterNack:
                begin
                    if (phaseCnt == '0)
                    begin
                        sdaEn  <= 1'b1;
                        sdaOut <= 1'b1;              // Single byte read ends here
                    end
                    if (bitEnd)
                        state <= stop;
                end
                stop:
                begin
                    if (phaseCnt == '0)
                    begin
                        sdaEn  <= 1'b1;
                        sdaOut <= 1'b0;
                    end
                    if (phaseCnt == fifth1)
                        sclReg <= 1'b1;
                    if (phaseCnt == fifth3)
                        sdaOut <= 1'b1;              // SDA rises while SCL high
                    if (bitEnd)
                        state <= finish;
                end
                finish:
                begin
                    done  <= 1'b1;
                    sdaEn <= 1'b0;
                    state <= waitRelease;
                end
                waitRelease:
                begin
                    if (startSig == 2'b00)
                        state <= idle;
                end
                default:
                    state <= idle;
            endcase
        end
    end

    // Data only moves with SCL low except in START and STOP
    assert property (@(posedge CLK) disable iff (!RSTn)
        (sdaLine != $past(sdaLine)) && !(state inside {start, restart, stop})
        |-> !sclReg && !$past(sclReg));

    // Sequencer holds one valid command steady until the master answers
    assert property (@(posedge CLK) disable iff (!RSTn) startSig != 2'b11);
    assert property (@(posedge CLK) disable iff (!RSTn)
        !(state inside {idle, waitRelease}) |-> $stable(startSig) && $stable(addr)
        && $stable(wrData));

endmodule

// File: logic/eepromSequencer.sv
`timescale 1ns/1ps

module eepromSequencer
    import eepromPkg::*;
(
    input  logic       CLK,
    input  logic       RSTn,
    input  logic       qEmpty,
    input  cmdOpT      qOp,
    input  logic [7:0] qAddr,
    input  logic [7:0] qData,
    output logic       qPop,
    output logic [1:0] startSig,
    output logic [7:0] addr,
    output logic [7:0] wrData,
    input  logic       done,
    input  logic [7:0] rdData,
    input  logic       ackErr,
    output logic       rspValid,
    output cmdOpT      rspOp,
    output logic [7:0] rspAddr,
    output logic [7:0] rspData,
    output logic       rspAckErr
);

    seqState    curState;
    cmdOpT      curOp;
    logic [7:0] curAddr;
    logic [7:0] curData;

    assign qPop = (curState == seqIdle) && !qEmpty;   // Pop in first idle cycle

    always_ff @(posedge CLK or negedge RSTn)
    begin
        if (!RSTn)
        begin
            curState <= seqIdle;
            startSig <= 2'b00;
        end
        else
        begin
            case (curState)
                seqIdle:
                begin
                    if (qPop)
                    begin
                        startSig <= (qOp == opRead) ? 2'b10 : 2'b01;
                        curState <= seqBusy;
                    end
                end
                seqBusy:
                begin
                    if (done)
                    begin
                        startSig <= 2'b00;           // Lets the master go idle
                        curState <= seqRespond;
                    end
                end
                default:
                    curState <= seqIdle;             // Single response cycle
            endcase
        end
    end

    // Command and response payload
    always_ff @(posedge CLK)
    begin
        if (qPop)
        begin
            curOp   <= qOp;
            curAddr <= qAddr;
            curData <= qData;
        end
        if (curState == seqBusy && done)
        begin
            rspData   <= (curOp == opRead) ? rdData : 8'h00;
            rspAckErr <= ackErr;
        end
    end

    assign addr     = curAddr;
    assign wrData   = curData;
    assign rspValid = (curState == seqRespond);
    assign rspOp    = curOp;
    assign rspAddr  = curAddr;

    // Master only finishes a command it was given
    assert property (@(posedge CLK) disable iff (!RSTn) done |-> curState == seqBusy);

endmodule

// File: logic/cmdQueue.sv
`timescale 1ns/1ps
`include "eeprom_defines.svh"

module cmdQueue
    import eepromPkg::*;
(
    input  logic       CLK,
    input  logic       RSTn,
    input  logic       push,
    input  cmdOpT      pushOp,
    input  logic [7:0] pushAddr,
    input  logic [7:0] pushData,
    input  logic       pop,
    output logic       empty,
    output logic       full,
    output cmdOpT      headOp,
    output logic [7:0] headAddr,
    output logic [7:0] headData
);

    localparam int depth = `CMD_QUEUE_DEPTH;
    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);
    localparam logic [ptrW-1:0] lastSlot = ptrW'(depth - 1);

    cmdOpT      opMem   [depth];
    logic [7:0] addrMem [depth];
    logic [7:0] dataMem [depth];

    logic [ptrW-1:0] rdPtr;
    logic [ptrW-1:0] wrPtr;
    logic [cntW-1:0] count;

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == lastSlot) ? '0 : ptr + 1'b1;   // Wrap for any depth
    endfunction

    always_ff @(posedge CLK)
    begin
        if (push)
        begin
            opMem[wrPtr]   <= pushOp;
            addrMem[wrPtr] <= pushAddr;
            dataMem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge CLK or negedge RSTn)
    begin
        if (!RSTn)
        begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wrPtr <= nextPtr(wrPtr);
            if (pop)
                rdPtr <= nextPtr(rdPtr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                 // Both or neither
            endcase
        end
    end

    assign empty    = (count == '0);
    assign full     = (count == cntW'(depth));
    assign headOp   = opMem[rdPtr];                  // Fall-through head
    assign headAddr = addrMem[rdPtr];
    assign headData = dataMem[rdPtr];

    // Host stalls on full, the sequencer only pops a valid head
    assert property (@(posedge CLK) disable iff (!RSTn) push |-> !full);
    assert property (@(posedge CLK) disable iff (!RSTn) pop |-> !empty);

endmodule

// File: logic/eepromPkg.sv
package eepromPkg;

    // Host command opcode
    typedef enum logic [0:0] {
        opWrite = 1'b0,                         // Write one byte
        opRead  = 1'b1                          // Random read of one byte
    } cmdOpT;

    // Bit-level I2C master
    typedef enum logic [3:0] {
        idle,                                   // Bus free, waiting for startSig
        start,                                  // START condition
        sendByte,                               // Eight bits out, MSB first
        ackWait,                                // Slave ACK slot
        restart,                                // Repeated START before read address
        readByte,                               // Eight bits in, MSB first
        masterNack,                             // Master NACK ends the read
        stop,                                   // STOP condition
        finish,                                 // Done pulse
        waitRelease                             // Hold until startSig drops
    } masterState;

    // Command sequencer
    typedef enum logic [1:0] {
        seqIdle,
        seqBusy,
        seqRespond
    } seqState;

endpackage

// File: logic/eeprom_defines.svh
`ifndef EEPROM_DEFINES_SVH
`define EEPROM_DEFINES_SVH

// Clock cycles per I2C bit, 100 kHz from a 50 MHz clock
// Must divide by five, the SCL and SDA edges sit on fifths of a bit
`define I2C_BIT_CYCLES 500

// Pending host commands the queue can hold
`define CMD_QUEUE_DEPTH 4

// 24C-style EEPROM with A2..A0 tied low
`define EEPROM_DEV_ADDR 7'b1010000

`endif
